// ==== Bender.yml ====
package:
  name: rob

sources:
  - files:
      - hdl/rob_cfg_pkg.sv
      - hdl/rob_op_pkg.sv
      - hdl/rob_fifo.sv
      - hdl/rob_entry_table.sv
      - hdl/rob_commit_unit.sv
      - hdl/rob_pointer_ctrl.sv
      - hdl/rob_top.sv
  - target: test
    files:
      - test/rob_assert.sv
      - test/rob_tb.sv

// ==== all.f ====
hdl/rob_cfg_pkg.sv
hdl/rob_op_pkg.sv
hdl/rob_fifo.sv
hdl/rob_entry_table.sv
hdl/rob_commit_unit.sv
hdl/rob_pointer_ctrl.sv
hdl/rob_top.sv
test/rob_assert.sv
test/rob_tb.sv

// ==== hdl/rob_cfg_pkg.sv ====
package rob_cfg_pkg;

    // reorder buffer sizing
    // eight slots, one always kept free so head == tail means empty
    localparam int rob_depth = 8;

    // pointer width, log2 of rob_depth
    localparam int rob_ptr_w = 3;

    // largest occupancy before full asserts
    localparam int rob_max_used = rob_depth - 1;

    // pending branch positions held in order
    localparam int br_fifo_depth = 4;

    // architectural register index width
    localparam int reg_idx_w = 5;

    // entry index into the buffer
    typedef logic [rob_ptr_w-1:0] rob_ptr_t;

    // rv32i register index, x0..x31
    typedef logic [reg_idx_w-1:0] reg_idx_t;

endpackage : rob_cfg_pkg

// ==== hdl/rob_commit_unit.sv ====
`timescale 1ns/1ns

module rob_commit_unit (
    input  rob_cfg_pkg::rob_ptr_t   head,
    input  rob_op_pkg::op_t         head_op,
    input  rob_cfg_pkg::reg_idx_t   head_rd,
    input  logic                    head_pred,
    input  logic                    head_taken,
    input  logic                    head_complete,
    input  logic                    head_allocated,
    input  logic                    flush_active,
    input  logic [1:0]              mem_offset,
    input  rob_cfg_pkg::rob_ptr_t   br_front,
    input  logic                    br_front_valid,
    input  rob_op_pkg::op_t         walk_op,
    input  rob_cfg_pkg::reg_idx_t   walk_rd,
    input  logic                    walk_allocated,
    output logic                    commit_fire,
    output logic                    commit_valid,
    output rob_op_pkg::commit_t     commit,
    output logic                    regfile_load,
    output logic                    mispredict,
    output logic                    ld_pc,
    output logic                    squash_valid,
    output rob_cfg_pkg::reg_idx_t   squash_rd
);

    rob_op_pkg::wmask_t wmask;
    logic               head_is_branch;
    logic               front_match;

    // head leaves once it is allocated and done, never during a walk
    assign commit_fire  = head_allocated & head_complete & ~flush_active;
    assign commit_valid = commit_fire;

    // store byte enables
    always_comb begin
        case (head_op)
            // aligned word
            rob_op_pkg::op_sw: wmask = 4'b1111;
            rob_op_pkg::op_sh: wmask = 4'b0011 << mem_offset;
            rob_op_pkg::op_sb: wmask = 4'b0001 << mem_offset;
            default:           wmask = '0;
        endcase
    end

    assign commit.op    = head_op;
    assign commit.rd    = head_rd;
    assign commit.wmask = wmask;

    assign regfile_load = commit_fire & rob_op_pkg::writes_reg(head_op);

    // the oldest pending branch must be the head branch
    assign head_is_branch = head_op == rob_op_pkg::op_branch;
    assign front_match    = br_front_valid & (br_front == head);

    // predicted direction disagrees with the resolved one
    assign mispredict = commit_fire & head_is_branch & front_match & (head_pred != head_taken);
    assign ld_pc      = mispredict;

    // tag reallocation for each squashed entry that owns an rd
    // the slot at the tail ends the walk and is never allocated
    assign squash_valid = flush_active & walk_allocated & rob_op_pkg::writes_reg(walk_op);
    assign squash_rd    = walk_rd;

endmodule : rob_commit_unit

// ==== hdl/rob_entry_table.sv ====
`timescale 1ns/1ns

module rob_entry_table (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 alloc_valid,
    input  rob_op_pkg::alloc_req_t               alloc,
    input  rob_cfg_pkg::rob_ptr_t                tail,
    input  logic [rob_cfg_pkg::rob_depth-1:0]    complete,
    input  logic                                 resolve_valid,
    input  rob_op_pkg::br_resolve_t              resolve,
    input  rob_cfg_pkg::rob_ptr_t                head,
    input  logic                                 commit_fire,
    input  logic                                 flush_active,
    input  rob_cfg_pkg::rob_ptr_t                walk_ptr,
    output rob_op_pkg::op_t                      head_op,
    output rob_cfg_pkg::reg_idx_t                head_rd,
    output logic                                 head_pred,
    output logic                                 head_taken,
    output logic                                 head_complete,
    output rob_op_pkg::op_t                      walk_op,
    output rob_cfg_pkg::reg_idx_t                walk_rd,
    output logic [rob_cfg_pkg::rob_depth-1:0]    allocated,
    output logic [rob_cfg_pkg::rob_depth-1:0]    completed
);

    rob_op_pkg::rob_entry_t               entry_q [rob_cfg_pkg::rob_depth];
    logic [rob_cfg_pkg::rob_depth-1:0]    alloc_q;
    logic [rob_cfg_pkg::rob_depth-1:0]    done_q;
    logic                                 alloc_en;

    // the issue queue is held off by full, but never write during a flush walk
    assign alloc_en = alloc_valid & ~flush_active;

    // payload per slot
    always_ff @(posedge clk) begin
        // branch outcome lands in its own slot
        if (resolve_valid) begin
            entry_q[resolve.idx].taken <= resolve.taken;
        end
        if (alloc_en) begin
            entry_q[tail].op    <= alloc.op;
            entry_q[tail].rd    <= alloc.rd;
            entry_q[tail].pred  <= alloc.pred;
            // branch starts as not taken until resolved
            entry_q[tail].taken <= 1'b0;
        end
    end

    // allocated and complete flags
    // later assignments win, so allocation at the tail overrides the clears
    always_ff @(posedge clk) begin
        if (rst) begin
            alloc_q <= '0;
            done_q  <= '0;
        end else begin
            // reservation stations may finish several entries at once
            done_q <= done_q | complete;
            if (commit_fire) begin
                alloc_q[head] <= 1'b0;
                done_q[head]  <= 1'b0;
            end
            // squash the walked entry, one per cycle
            if (flush_active) begin
                alloc_q[walk_ptr] <= 1'b0;
                done_q[walk_ptr]  <= 1'b0;
            end
            if (alloc_en) begin
                alloc_q[tail] <= 1'b1;
                done_q[tail]  <= 1'b0;
            end
        end
    end

    // head entry, feeds the commit decision
    assign head_op       = entry_q[head].op;
    assign head_rd       = entry_q[head].rd;
    assign head_pred     = entry_q[head].pred;
    assign head_taken    = entry_q[head].taken;
    assign head_complete = done_q[head];

    // walk entry, feeds the squash pulse
    assign walk_op = entry_q[walk_ptr].op;
    assign walk_rd = entry_q[walk_ptr].rd;

    assign allocated = alloc_q;
    assign completed = done_q;

endmodule : rob_entry_table

// ==== hdl/rob_fifo.sv ====
`timescale 1ns/1ns

module rob_fifo #(
    parameter type data_t = logic,
    parameter int  depth  = 4
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  push,
    input  data_t data_in,
    input  logic  pop,
    output data_t data_out,
    output logic  valid,
    output logic  ready
);

    data_t                    mem [depth];
    logic [$clog2(depth)-1:0] rd_ptr;
    logic [$clog2(depth)-1:0] wr_ptr;
    logic [$clog2(depth):0]   count;
    logic                     do_push;
    logic                     do_pop;

    assign valid = count != '0;
    assign ready = count != ($clog2(depth)+1)'(depth);

    // push into a full queue or pop from an empty one is dropped
    assign do_push = push & ready;
    assign do_pop  = pop & valid;

    // oldest item, visible without a pop
    assign data_out = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap at depth, not only at a power of two
            if (do_push) begin
                wr_ptr <= (wr_ptr == ($clog2(depth))'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ($clog2(depth))'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop together keep the count
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule : rob_fifo

// ==== hdl/rob_op_pkg.sv ====
package rob_op_pkg;

    // instruction classes tracked by the rob
    // loads are not handled here
    typedef enum logic [3:0] {
        op_alu    = 4'd0,
        op_lui    = 4'd1,
        op_auipc  = 4'd2,
        op_jal    = 4'd3,
        op_jalr   = 4'd4,
        op_branch = 4'd5,
        op_sb     = 4'd6,
        op_sh     = 4'd7,
        op_sw     = 4'd8
    } op_t;

    // byte enables for a store, bit 0 is the lowest byte
    typedef logic [3:0] wmask_t;

    // issue request, rd holds the store source register for stores
    typedef struct packed {
        op_t                   op;
        rob_cfg_pkg::reg_idx_t rd;
        logic                  pred;
    } alloc_req_t;

    // branch outcome from the branch unit
    typedef struct packed {
        rob_cfg_pkg::rob_ptr_t idx;
        logic                  taken;
    } br_resolve_t;

    // head entry leaving the buffer
    typedef struct packed {
        op_t                   op;
        rob_cfg_pkg::reg_idx_t rd;
        wmask_t                wmask;
    } commit_t;

    // payload kept per slot
    typedef struct packed {
        op_t                   op;
        rob_cfg_pkg::reg_idx_t rd;
        logic                  pred;
        logic                  taken;
    } rob_entry_t;

    function automatic logic is_store(op_t op);
        return op inside {op_sb, op_sh, op_sw};
    endfunction

    // branches and stores leave the register file alone
    function automatic logic writes_reg(op_t op);
        return !(is_store(op) || op == op_branch);
    endfunction

endpackage : rob_op_pkg

// ==== hdl/rob_pointer_ctrl.sv ====
`timescale 1ns/1ns

module rob_pointer_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  alloc_valid,
    input  logic                  commit_fire,
    input  logic                  mispredict,
    output rob_cfg_pkg::rob_ptr_t head,
    output rob_cfg_pkg::rob_ptr_t tail,
    output rob_cfg_pkg::rob_ptr_t walk_ptr,
    output logic                  flush_active,
    output logic                  full
);

    rob_cfg_pkg::rob_ptr_t occupancy;
    logic                  walk_done;

    // pointers wrap on their own width, tail minus head is the entry count
    assign occupancy = tail - head;

    // walk has passed the youngest entry
    assign walk_done = walk_ptr == tail;

    // one slot stays free, and the walk blocks issue too
    assign full = (occupancy == rob_cfg_pkg::rob_ptr_t'(rob_cfg_pkg::rob_max_used))
                | flush_active;

    always_ff @(posedge clk) begin
        if (rst) begin
            head         <= '0;
            tail         <= '0;
            walk_ptr     <= '0;
            flush_active <= 1'b0;
        end else if (flush_active) begin
            // head holds still for the whole walk
            if (walk_done) begin
                flush_active <= 1'b0;
                // drop every younger entry at once
                tail         <= head;
            end else begin
                walk_ptr <= walk_ptr + 1'b1;
            end
        end else begin
            if (alloc_valid) begin
                tail <= tail + 1'b1;
            end
            if (commit_fire) begin
                head <= head + 1'b1;
            end
            // mispredicting branch has just left, walk from the entry behind it
            if (mispredict) begin
                flush_active <= 1'b1;
                walk_ptr     <= head + 1'b1;
            end
        end
    end

endmodule : rob_pointer_ctrl

// ==== hdl/rob_top.sv ====
`timescale 1ns/1ns

module rob_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              alloc_valid,
    input  rob_op_pkg::alloc_req_t            alloc,
    input  logic [rob_cfg_pkg::rob_depth-1:0] complete,
    input  logic                              resolve_valid,
    input  rob_op_pkg::br_resolve_t           resolve,
    input  logic [1:0]                        mem_offset,
    output logic                              full,
    output logic                              commit_valid,
    output rob_op_pkg::commit_t               commit,
    output logic                              regfile_load,
    output logic                              ld_pc,
    output logic                              flush_active,
    output logic                              squash_valid,
    output rob_cfg_pkg::reg_idx_t             squash_rd,
    output rob_cfg_pkg::rob_ptr_t             head,
    output rob_cfg_pkg::rob_ptr_t             tail,
    output logic [rob_cfg_pkg::rob_depth-1:0] allocated,
    output logic [rob_cfg_pkg::rob_depth-1:0] completed
);

    rob_op_pkg::op_t       head_op;
    rob_cfg_pkg::reg_idx_t head_rd;
    logic                  head_pred;
    logic                  head_taken;
    logic                  head_complete;
    logic                  head_allocated;
    rob_op_pkg::op_t       walk_op;
    rob_cfg_pkg::reg_idx_t walk_rd;
    logic                  walk_allocated;
    rob_cfg_pkg::rob_ptr_t walk_ptr;
    logic                  commit_fire;
    logic                  mispredict;
    rob_cfg_pkg::rob_ptr_t br_front;
    logic                  br_front_valid;
    logic                  br_ready;
    logic                  br_push;
    logic                  br_pop;
    logic                  br_clear;

    assign head_allocated = allocated[head];
    assign walk_allocated = allocated[walk_ptr];

    // branch order queue, tail index of each issued branch
    assign br_push  = alloc_valid & ~flush_active & br_ready
                    & (alloc.op == rob_op_pkg::op_branch);
    assign br_pop   = commit_fire & (head_op == rob_op_pkg::op_branch);
    // younger branches are squashed along with their entries
    assign br_clear = rst | flush_active;

    rob_entry_table rob_entry_table_inst (
        .clk           (clk),
        .rst           (rst),
        .alloc_valid   (alloc_valid),
        .alloc         (alloc),
        .tail          (tail),
        .complete      (complete),
        .resolve_valid (resolve_valid),
        .resolve       (resolve),
        .head          (head),
        .commit_fire   (commit_fire),
        .flush_active  (flush_active),
        .walk_ptr      (walk_ptr),
        .head_op       (head_op),
        .head_rd       (head_rd),
        .head_pred     (head_pred),
        .head_taken    (head_taken),
        .head_complete (head_complete),
        .walk_op       (walk_op),
        .walk_rd       (walk_rd),
        .allocated     (allocated),
        .completed     (completed)
    );

    rob_pointer_ctrl rob_pointer_ctrl_inst (
        .clk          (clk),
        .rst          (rst),
        .alloc_valid  (alloc_valid),
        .commit_fire  (commit_fire),
        .mispredict   (mispredict),
        .head         (head),
        .tail         (tail),
        .walk_ptr     (walk_ptr),
        .flush_active (flush_active),
        .full         (full)
    );

    rob_commit_unit rob_commit_unit_inst (
        .head           (head),
        .head_op        (head_op),
        .head_rd        (head_rd),
        .head_pred      (head_pred),
        .head_taken     (head_taken),
        .head_complete  (head_complete),
        .head_allocated (head_allocated),
        .flush_active   (flush_active),
        .mem_offset     (mem_offset),
        .br_front       (br_front),
        .br_front_valid (br_front_valid),
        .walk_op        (walk_op),
        .walk_rd        (walk_rd),
        .walk_allocated (walk_allocated),
        .commit_fire    (commit_fire),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .regfile_load   (regfile_load),
        .mispredict     (mispredict),
        .ld_pc          (ld_pc),
        .squash_valid   (squash_valid),
        .squash_rd      (squash_rd)
    );

    rob_fifo #(
        .data_t (rob_cfg_pkg::rob_ptr_t),
        .depth  (rob_cfg_pkg::br_fifo_depth)
    ) br_fifo_inst (
        .clk      (clk),
        .rst      (br_clear),
        .push     (br_push),
        .data_in  (tail),
        .pop      (br_pop),
        .data_out (br_front),
        .valid    (br_front_valid),
        .ready    (br_ready)
    );

endmodule : rob_top

// ==== test/rob_assert.sv ====
`timescale 1ns/1ns

module rob_assert (
    input logic                              clk,
    input logic                              rst,
    input logic                              alloc_valid,
    input logic [rob_cfg_pkg::rob_depth-1:0] complete,
    input logic [1:0]                        mem_offset,
    input logic                              full,
    input logic                              commit_valid,
    input rob_op_pkg::commit_t               commit,
    input logic                              regfile_load,
    input logic                              ld_pc,
    input logic                              flush_active,
    input logic                              squash_valid,
    input rob_cfg_pkg::rob_ptr_t             head,
    input rob_cfg_pkg::rob_ptr_t             tail,
    input logic [rob_cfg_pkg::rob_depth-1:0] allocated,
    input logic [rob_cfg_pkg::rob_depth-1:0] completed
);

    // failed assertions so far
    int                                fail_count = 0;
    logic                              exp_load;
    logic [3:0]                        exp_mask;
    logic [rob_cfg_pkg::rob_depth-1:0] done_ref;

    // completion pulses seen since each slot was last allocated
    always_ff @(posedge clk) begin
        if (rst) begin
            done_ref <= '0;
        end else begin
            done_ref <= done_ref | complete;
            // a fresh entry starts incomplete
            if (alloc_valid) begin
                done_ref[tail] <= 1'b0;
            end
        end
    end

    // branches and stores leave the register file alone
    assign exp_load = !(commit.op inside {rob_op_pkg::op_branch, rob_op_pkg::op_sb,
                                          rob_op_pkg::op_sh, rob_op_pkg::op_sw});

    // byte enables built one byte at a time
    always_comb begin
        exp_mask = 4'b0000;
        if (commit.op == rob_op_pkg::op_sw) begin
            exp_mask = 4'b1111;
        end
        if (commit.op == rob_op_pkg::op_sb || commit.op == rob_op_pkg::op_sh) begin
            exp_mask[mem_offset] = 1'b1;
        end
        // upper byte of a halfword falls off the word at offset three
        if (commit.op == rob_op_pkg::op_sh && mem_offset != 2'd3) begin
            exp_mask[mem_offset + 2'd1] = 1'b1;
        end
    end

    // control outputs idle right after a reset edge
    a_reset_quiet: assert property (@(posedge clk)
        rst |=> !commit_valid && !regfile_load && !ld_pc && !flush_active
                && !squash_valid && !full && head == '0 && tail == '0)
    else begin
        $error("outputs not idle after reset");
        fail_count++;
    end

    // head leaves exactly when allocated and complete with no walk running
    a_commit_done: assert property (@(posedge clk) disable iff (rst)
        commit_valid == (allocated[head] && done_ref[head] && !flush_active))
    else begin
        $error("commit_valid disagrees with the head entry state");
        fail_count++;
    end

    // completion flags of live entries follow the completion pulses
    a_done_flags: assert property (@(posedge clk) disable iff (rst)
        (completed & allocated) == (done_ref & allocated))
    else begin
        $error("completed flags disagree with the completion pulses");
        fail_count++;
    end

    // issue queue honours back-pressure
    a_no_alloc_full: assert property (@(posedge clk) disable iff (rst)
        full |-> !alloc_valid)
    else begin
        $error("allocation while full");
        fail_count++;
    end

    a_full_rule: assert property (@(posedge clk) disable iff (rst)
        full == (flush_active || $countones(allocated) == rob_cfg_pkg::rob_max_used))
    else begin
        $error("full disagrees with occupancy and flush state");
        fail_count++;
    end

    a_regfile_rule: assert property (@(posedge clk) disable iff (rst)
        regfile_load == (commit_valid && exp_load))
    else begin
        $error("regfile_load wrong for committed class");
        fail_count++;
    end

    a_store_mask: assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> commit.wmask == exp_mask)
    else begin
        $error("store byte mask wrong");
        fail_count++;
    end

    // flush starts exactly one cycle after ld_pc
    a_flush_start: assert property (@(posedge clk) disable iff (rst)
        $rose(flush_active) == $past(ld_pc))
    else begin
        $error("flush start not tied to ld_pc");
        fail_count++;
    end

    a_flush_end: assert property (@(posedge clk) disable iff (rst)
        $fell(flush_active) |-> tail == head && allocated == '0)
    else begin
        $error("buffer not empty when flush ended");
        fail_count++;
    end

endmodule : rob_assert

// ==== test/rob_tb.sv ====
`timescale 1ns/1ns

module rob_tb;

    localparam int wait_limit = 200;

    logic                              clk;
    logic                              rst;
    logic                              alloc_valid;
    rob_op_pkg::alloc_req_t            alloc;
    logic [rob_cfg_pkg::rob_depth-1:0] complete;
    logic                              resolve_valid;
    rob_op_pkg::br_resolve_t           resolve;
    logic [1:0]                        mem_offset;
    logic                              full;
    logic                              commit_valid;
    rob_op_pkg::commit_t               commit;
    logic                              regfile_load;
    logic                              ld_pc;
    logic                              flush_active;
    logic                              squash_valid;
    rob_cfg_pkg::reg_idx_t             squash_rd;
    rob_cfg_pkg::rob_ptr_t             head;
    rob_cfg_pkg::rob_ptr_t             tail;
    logic [rob_cfg_pkg::rob_depth-1:0] allocated;
    logic [rob_cfg_pkg::rob_depth-1:0] completed;

    // entries in allocation order, and rds owed a squash pulse
    rob_op_pkg::rob_entry_t ref_q[$];
    rob_cfg_pkg::reg_idx_t  squash_q[$];
    logic [31:0]            lfsr;
    logic                   flush_seen;
    int                     errors;
    int                     tests_run;
    int                     tests_failed;

    rob_top rob_top_inst (.*);

    bind rob_top rob_assert rob_assert_inst (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] random_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // any class but branch
    function automatic rob_op_pkg::op_t random_op();
        logic [3:0] v;
        v = 4'(random_bits(3));
        if (v >= 4'd5) begin
            v = v + 4'd1;
        end
        return rob_op_pkg::op_t'(v);
    endfunction

    function automatic logic writes_dest(rob_op_pkg::op_t op);
        return !(op inside {rob_op_pkg::op_branch, rob_op_pkg::op_sb,
                            rob_op_pkg::op_sh, rob_op_pkg::op_sw});
    endfunction

    function automatic int total_errors();
        return errors + rob_top_inst.rob_assert_inst.fail_count;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $finish;
    endtask

    task automatic wait_room();
        int n;
        n = 0;
        while (full) begin
            next_cycle();
            n++;
            if (n > wait_limit) begin
                abort_run("timeout waiting for full to fall");
            end
        end
    endtask

    // every entry committed or squashed, walk over
    task automatic wait_drained();
        int n;
        n = 0;
        while (ref_q.size() != 0 || flush_active) begin
            mem_offset = 2'(random_bits(2));
            next_cycle();
            n++;
            if (n > wait_limit) begin
                abort_run("timeout waiting for the reorder buffer to drain");
            end
        end
    endtask

    // kind 0 mixed, 1 stores, 2 mispredicted branch first, 3 correct branch first
    task automatic run_test(input string name, input int kind, input int n);
        rob_op_pkg::rob_entry_t            e;
        rob_cfg_pkg::rob_ptr_t             br_idx;
        logic                              br_taken;
        logic [rob_cfg_pkg::rob_depth-1:0] pending;
        logic [1:0]                        v;
        int                                pick;
        int                                errs_before;
        errs_before = total_errors();
        pending = '0;
        br_idx = '0;
        br_taken = 1'b0;
        for (int i = 0; i < n; i++) begin
            wait_room();
            e.op = random_op();
            e.rd = 5'(random_bits(5));
            e.pred = random_bits(1) != 0;
            e.taken = 1'b0;
            if (kind == 1) begin
                v = 2'(random_bits(2));
                e.op = (v == 2'd0) ? rob_op_pkg::op_sb :
                       (v == 2'd1) ? rob_op_pkg::op_sh : rob_op_pkg::op_sw;
            end
            if (kind >= 2 && i == 0) begin
                e.op = rob_op_pkg::op_branch;
                e.taken = (kind == 3) ? e.pred : !e.pred;
                br_idx = tail;
                br_taken = e.taken;
            end
            alloc_valid = 1'b1;
            alloc.op = e.op;
            alloc.rd = e.rd;
            alloc.pred = e.pred;
            pending[tail] = 1'b1;
            ref_q.push_back(e);
            next_cycle();
            alloc_valid = 1'b0;
        end
        if (kind >= 2) begin
            resolve_valid = 1'b1;
            resolve.idx = br_idx;
            resolve.taken = br_taken;
            next_cycle();
            resolve_valid = 1'b0;
        end
        // finish entries in random order, one per cycle
        while (pending != '0) begin
            pick = int'(random_bits(3));
            while (!pending[pick]) begin
                pick = (pick + 1) % rob_cfg_pkg::rob_depth;
            end
            complete = '0;
            complete[pick] = 1'b1;
            pending[pick] = 1'b0;
            mem_offset = 2'(random_bits(2));
            next_cycle();
        end
        complete = '0;
        wait_drained();
        tests_run++;
        if (total_errors() != errs_before) begin
            tests_failed++;
            $display("test %s failed, %0d errors", name, total_errors() - errs_before);
        end else begin
            $display("test %s ok", name);
        end
    endtask

    // outputs are settled mid cycle
    always @(negedge clk) begin : monitor
        rob_op_pkg::rob_entry_t exp_e;
        rob_cfg_pkg::reg_idx_t  exp_rd;
        logic                   exp_ld;
        if (!rst && commit_valid) begin
            if (ref_q.size() == 0) begin
                $display("commit seen with no entry outstanding, head %0d", head);
                errors++;
            end else begin
                exp_e = ref_q.pop_front();
                if (commit.op != exp_e.op) begin
                    $display("MISMATCH commit.op got %h expected %h", commit.op, exp_e.op);
                    errors++;
                end
                if (commit.rd != exp_e.rd) begin
                    $display("MISMATCH commit.rd got %h expected %h", commit.rd, exp_e.rd);
                    errors++;
                end
                exp_ld = exp_e.op == rob_op_pkg::op_branch && exp_e.pred != exp_e.taken;
                if (ld_pc != exp_ld) begin
                    $display("MISMATCH ld_pc got %h expected %h", ld_pc, exp_ld);
                    errors++;
                end
                // younger entries die, writers hand their tag back in order
                if (exp_ld) begin
                    foreach (ref_q[i]) begin
                        if (writes_dest(ref_q[i].op)) begin
                            squash_q.push_back(ref_q[i].rd);
                        end
                    end
                    ref_q.delete();
                end
            end
        end
        if (!rst && squash_valid) begin
            if (squash_q.size() == 0) begin
                $display("squash pulse with no younger register writer left");
                errors++;
            end else begin
                exp_rd = squash_q.pop_front();
                if (squash_rd != exp_rd) begin
                    $display("MISMATCH squash_rd got %h expected %h", squash_rd, exp_rd);
                    errors++;
                end
            end
        end
        if (!rst && flush_seen && !flush_active && squash_q.size() != 0) begin
            $display("flush ended with %0d squash pulses missing", squash_q.size());
            errors++;
            squash_q.delete();
        end
        flush_seen = flush_active;
    end

    initial begin
        lfsr = 32'hf4a2;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        flush_seen = 1'b0;
        rst = 1'b1;
        alloc_valid = 1'b0;
        alloc = '0;
        complete = '0;
        resolve_valid = 1'b0;
        resolve = '0;
        mem_offset = '0;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        run_test("order", 0, 6);
        run_test("full", 0, 7);
        run_test("stores", 1, 7);
        run_test("mispredict", 2, 6);
        run_test("predict_ok", 3, 5);
        run_test("mispredict_full", 2, 7);
        run_test("mixed", 0, 7);
        // let the last assertions sample
        next_cycle();
        $display("tests %0d, failed %0d, checker errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, rob_top_inst.rob_assert_inst.fail_count);
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : rob_tb
